// ==== Bender.yml ====
package:
  name: sof_dev

sources:
  - files:
      - source/sof_bus_pkg.sv
      - source/sof_board_pkg.sv
      - source/rst_seq.sv
      - source/dev_decoder.sv
      - source/board_input.sv
      - source/board_regs.sv
      - source/sof_dev_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_sof_dev.sv

// ==== build.f ====
+incdir+dv
source/sof_bus_pkg.sv
source/sof_board_pkg.sv
source/rst_seq.sv
source/dev_decoder.sv
source/board_input.sv
source/board_regs.sv
source/sof_dev_top.sv
dv/tb_sof_dev.sv

// ==== dv/tb_sof_cases.svh ====
`ifndef TB_SOF_CASES_SVH
`define TB_SOF_CASES_SVH

// what the read data is compared against
typedef enum int {
	CHK_NONE,
	CHK_DATA,
	CHK_SW
} chk_e;

typedef struct {
	string     name;
	bit        rand_sw;
	bit [3:0]  btn;
	int        hold;
	bit        glitch;
	bit        we;
	bit [7:0]  slot;
	bit [5:0]  offset;
	bit [3:0]  sel;
	bit [31:0] wdata;
	chk_e      chk;
	bit [31:0] exp_rd;
	bit [7:0]  exp_led;
	bit        exp_irq;
} case_t;

localparam int HOLD      = 2 * DEBOUNCE_CYCLES;
localparam int GLITCH    = DEBOUNCE_CYCLES / 2;
localparam int NUM_CASES = 21;

// name, rand_sw, btn, hold, glitch, we, slot, offset, sel, wdata, check, rd, led, irq
case_t cases [NUM_CASES] = '{
	'{"led_write", 0, 0, 0, 0, 1, SLOT_BOARD, REG_LED, 'h1, 'h5a, CHK_NONE, 0, 'h5a, 0},
	'{"led_read", 0, 0, 0, 0, 0, SLOT_BOARD, REG_LED, 'h1, 0, CHK_DATA, 'h5a, 'h5a, 0},
	'{"led_sel_off", 0, 0, 0, 0, 1, SLOT_BOARD, REG_LED, 'he, 'h3c, CHK_NONE, 0, 'h5a, 0},
	'{"led_kept", 0, 0, 0, 0, 0, SLOT_BOARD, REG_LED, 'hf, 0, CHK_DATA, 'h5a, 'h5a, 0},
	'{"sw_random", 1, 0, HOLD, 0, 0, SLOT_BOARD, REG_SWITCH, 'hf, 0, CHK_SW, 0, 'h5a, 0},
	'{"sw_glitch", 1, 0, GLITCH, 1, 0, SLOT_BOARD, REG_SWITCH, 'hf, 0, CHK_SW, 0, 'h5a, 0},
	'{"btn_hold", 0, 'h8, HOLD, 0, 0, SLOT_BOARD, REG_BTN, 'hf, 0, CHK_DATA, 'h8, 'h5a, 0},
	'{"btn_glitch", 0, 'h9, GLITCH, 1, 0, SLOT_BOARD, REG_BTN, 'hf, 0, CHK_DATA, 'h8, 'h5a, 0},
	'{"pend_set", 0, 'h8, 0, 0, 0, SLOT_BOARD, REG_IRQ_PEND, 'hf, 0, CHK_DATA, 'h8, 'h5a, 0},
	'{"irq_enable", 0, 'h8, 0, 0, 1, SLOT_BOARD, REG_IRQ_EN, 'h1, 'h8, CHK_NONE, 0, 'h5a, 1},
	'{"en_read", 0, 'h8, 0, 0, 0, SLOT_BOARD, REG_IRQ_EN, 'hf, 0, CHK_DATA, 'h8, 'h5a, 1},
	'{"pend_clear", 0, 'h8, 0, 0, 1, SLOT_BOARD, REG_IRQ_PEND, 'h1, 'h8, CHK_NONE, 0, 'h5a, 0},
	'{"pend_cleared", 0, 'h8, 0, 0, 0, SLOT_BOARD, REG_IRQ_PEND, 'hf, 0, CHK_DATA, 0, 'h5a, 0},
	'{"btn_release", 0, 0, HOLD, 0, 0, SLOT_BOARD, REG_BTN, 'hf, 0, CHK_DATA, 0, 'h5a, 0},
	'{"right_press", 0, 'h4, HOLD, 0, 0, SLOT_BOARD, REG_IRQ_PEND, 'hf, 0, CHK_DATA, 'h4, 'h5a, 0},
	'{"uart_read", 0, 'h4, 0, 0, 0, SLOT_UART, REG_LED, 'hf, 0, CHK_DATA, 0, 'h5a, 0},
	'{"uart_write", 0, 'h4, 0, 0, 1, SLOT_UART, REG_LED, 'hf, 'hff, CHK_NONE, 0, 'h5a, 0},
	'{"bad_off_write", 0, 'h4, 0, 0, 1, SLOT_BOARD, 'h10, 'hf, 'hff, CHK_NONE, 0, 'h5a, 0},
	'{"bad_off_read", 0, 'h4, 0, 0, 0, SLOT_BOARD, 'h10, 'hf, 0, CHK_DATA, 0, 'h5a, 0},
	'{"led_final", 0, 'h4, 0, 0, 0, SLOT_BOARD, REG_LED, 'hf, 0, CHK_DATA, 'h5a, 'h5a, 0},
	'{"en_final", 0, 'h4, 0, 0, 0, SLOT_BOARD, REG_IRQ_EN, 'hf, 0, CHK_DATA, 'h8, 'h5a, 0}
};

`endif

// ==== dv/tb_sof_dev.sv ====
`timescale 1ns/10ps

module tb_sof_dev import sof_bus_pkg::*, sof_board_pkg::*; ();

	localparam int ACK_LIMIT = 16;

	`include "tb_sof_cases.svh"

	localparam int WATCHDOG_CYCLES =
		NUM_CASES * (4 * DEBOUNCE_CYCLES + 20) + 4 * RST_STRETCH;

	logic                   clk_cpu;
	logic                   rst_n_i;
	logic                   pll_locked;
	logic                   rst_btn;
	dev_req_t               bus_req;
	dev_rsp_t               bus_rsp;
	logic [SWITCH_BITS-1:0] switches;
	btn_t                   buttons;
	logic [LED_BITS-1:0]    led;
	logic                   irq;
	logic                   sys_rst;

	int                     seed = 32'h4a80;
	int                     test_errs;
	int                     pass_count;
	int                     fail_count;
	logic [SWITCH_BITS-1:0] sw_held;
	btn_t                   btn_held;

	sof_dev_top DUT (
		.clk_cpu      (clk_cpu),
		.rst_n_i      (rst_n_i),
		.pll_locked_i (pll_locked),
		.rst_btn_i    (rst_btn),
		.bus_req_i    (bus_req),
		.bus_rsp_o    (bus_rsp),
		.switch_i     (switches),
		.btn_i        (buttons),
		.led_o        (led),
		.irq_o        (irq),
		.sys_rst_o    (sys_rst)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #5 clk_cpu = ~clk_cpu;
	end

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0) begin
			$display("%-14s passed", name);
			pass_count++;
		end else begin
			$display("%-14s failed with %0d mismatches", name, test_errs);
			fail_count++;
		end
		test_errs = 0;
	endtask

	// request goes out on a falling edge, ack expected at the next one
	task automatic bus_access(input string name, input bit we, input logic [7:0] slot,
		input logic [5:0] offset, input logic [3:0] sel, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int cycles;
		rdata = '0;
		cycles = 0;
		bus_req = '{cyc: 1'b1, stb: 1'b1, addr: {slot, offset}, sel: sel, we: we, data: wdata};
		do begin
			@(negedge clk_cpu);
			cycles++;
		end while (!bus_rsp.ack && cycles < ACK_LIMIT);
		if (!bus_rsp.ack) begin
			$display("%s: no ack arrived within %0d cycles", name, ACK_LIMIT);
			test_errs++;
		end else begin
			rdata = bus_rsp.data;
			compare({name, " ack cycles"}, 1, cycles);
		end
		// stb still high across the ack cycle
		@(negedge clk_cpu);
		compare({name, " second ack"}, 0, bus_rsp.ack);
		bus_req = '0;
	endtask

	task automatic run_case(input case_t c);
		logic [31:0]            rdata;
		logic [SWITCH_BITS-1:0] sw_next;
		sw_next = sw_held;
		if (c.rand_sw) begin
			sw_next = sw_held ^ (SWITCH_BITS'($random(seed)) | SWITCH_BITS'(1));
		end
		switches = sw_next;
		buttons = btn_t'(c.btn);
		repeat (c.hold) @(negedge clk_cpu);
		if (c.glitch) begin
			switches = sw_held;
			buttons = btn_held;
			// poll while a wrongly taken glitch would still be visible
			repeat (HOLD / 4) begin
				bus_access(c.name, 1'b0, SLOT_BOARD, REG_SWITCH, 4'hf, '0, rdata);
				compare({c.name, " switches"}, 32'(sw_held), rdata);
				bus_access(c.name, 1'b0, SLOT_BOARD, REG_BTN, 4'hf, '0, rdata);
				compare({c.name, " buttons"}, 32'(btn_held), rdata);
			end
		end else begin
			sw_held = sw_next;
			btn_held = btn_t'(c.btn);
		end
		bus_access(c.name, c.we, c.slot, c.offset, c.sel, c.wdata, rdata);
		if (c.chk == CHK_DATA) begin
			compare({c.name, " read data"}, c.exp_rd, rdata);
		end else if (c.chk == CHK_SW) begin
			compare({c.name, " read data"}, 32'(sw_held), rdata);
		end
		compare({c.name, " led_o"}, 32'(c.exp_led), 32'(led));
		compare({c.name, " irq_o"}, 32'(c.exp_irq), 32'(irq));
		finish_test(c.name);
	endtask

	initial begin
		rst_n_i = 1'b0;
		pll_locked = 1'b1;
		rst_btn = 1'b0;
		bus_req = '0;
		switches = '0;
		buttons = '0;
		sw_held = '0;
		btn_held = '0;
		test_errs = 0;
		pass_count = 0;
		fail_count = 0;
		repeat (3) @(negedge clk_cpu);
		rst_n_i = 1'b1;
		repeat (RST_STRETCH - 1) @(negedge clk_cpu);
		compare("rst_stretch held", 1, 32'(sys_rst));
		repeat (3) @(negedge clk_cpu);
		compare("rst_stretch released", 0, 32'(sys_rst));
		finish_test("rst_stretch");
		rst_btn = 1'b1;
		@(negedge clk_cpu);
		compare("rst_button raised", 1, 32'(sys_rst));
		rst_btn = 1'b0;
		repeat (RST_STRETCH + 2) @(negedge clk_cpu);
		compare("rst_button released", 0, 32'(sys_rst));
		finish_test("rst_button");
		for (int i = 0; i < NUM_CASES; i++) begin
			run_case(cases[i]);
		end
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_cpu);
		$display("run timed out after %0d cycles before all cases finished", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== source/board_input.sv ====
`timescale 1ns/10ps

module board_input import sof_board_pkg::*; (
	input  logic                   clk_cpu,
	input  logic                   rst_n_i,
	input  logic [SWITCH_BITS-1:0] switch_i,
	input  btn_t                   btn_i,
	output logic [SWITCH_BITS-1:0] sw_stable_o,
	output btn_t                   btn_stable_o,
	output btn_t                   btn_press_o
);

	logic [INPUT_BITS-1:0]                         meta_q;
	logic [INPUT_BITS-1:0]                         sync_q;
	logic [INPUT_BITS-1:0]                         stable_q;
	logic [INPUT_BITS-1:0][DEBOUNCE_CNT_BITS-1:0] cnt_q;
	btn_t                                          btn_last_q;

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			meta_q <= '0;
			sync_q <= '0;
		end else begin
			meta_q <= {btn_i, switch_i};
			sync_q <= meta_q;
		end
	end

	// count how long each synced bit has differed from its stable level
	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stable_q <= '0;
			cnt_q    <= '0;
		end else begin
			for (int i = 0; i < INPUT_BITS; i++) begin
				if (sync_q[i] == stable_q[i]) begin
					cnt_q[i] <= '0;
				end else if (cnt_q[i] == DEBOUNCE_CNT_BITS'(DEBOUNCE_CYCLES - 1)) begin
					stable_q[i] <= sync_q[i];
					cnt_q[i]    <= '0;
				end else begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	assign sw_stable_o  = stable_q[SWITCH_BITS-1:0];
	assign btn_stable_o = btn_t'(stable_q[INPUT_BITS-1 -: BTN_BITS]);

	// rising edge of the debounced buttons
	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			btn_last_q  <= '0;
			btn_press_o <= '0;
		end else begin
			btn_last_q  <= btn_stable_o;
			btn_press_o <= btn_t'(btn_stable_o & ~btn_last_q);
		end
	end

endmodule

// ==== source/board_regs.sv ====
`timescale 1ns/10ps

module board_regs import sof_bus_pkg::*, sof_board_pkg::*; (
	input  logic                   clk_cpu,
	input  logic                   rst_n_i,
	input  logic                   sys_rst_i,
	input  periph_req_t            req_i,
	output dev_rsp_t               rsp_o,
	input  logic [SWITCH_BITS-1:0] sw_stable_i,
	input  btn_t                   btn_stable_i,
	input  btn_t                   btn_press_i,
	output logic [LED_BITS-1:0]    led_o,
	output logic                   irq_o
);

	board_reg_e            reg_sel;
	logic                  ack_q;
	logic                  wr_en;
	logic [DATA_BITS-1:0]  rdata_d;
	logic [DATA_BITS-1:0]  rdata_q;
	logic [BTN_BITS-1:0]   irq_pend_q;
	logic [BTN_BITS-1:0]   irq_en_q;
	logic [BTN_BITS-1:0]   pend_clr;

	assign reg_sel = board_reg_e'(req_i.offset);

	// only byte lane 0 is writable, once per request
	assign wr_en = req_i.cs & req_i.we & req_i.sel[0] & ~ack_q;

	always_comb begin
		rdata_d = '0;
		case (reg_sel)
			REG_SWITCH:   rdata_d[SWITCH_BITS-1:0] = sw_stable_i;
			REG_LED:      rdata_d[LED_BITS-1:0] = led_o;
			REG_BTN:      rdata_d[BTN_BITS-1:0] = btn_stable_i;
			REG_IRQ_PEND: rdata_d[BTN_BITS-1:0] = irq_pend_q;
			REG_IRQ_EN:   rdata_d[BTN_BITS-1:0] = irq_en_q;
			default:      rdata_d = '0;
		endcase
	end

	always_comb begin
		pend_clr = '0;
		if (wr_en && reg_sel == REG_IRQ_PEND) begin
			pend_clr = req_i.data[BTN_BITS-1:0];
		end
	end

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q   <= 1'b0;
			rdata_q <= '0;
		end else if (sys_rst_i) begin
			ack_q   <= 1'b0;
			rdata_q <= '0;
		end else begin
			ack_q   <= req_i.cs & ~ack_q;
			rdata_q <= rdata_d;
		end
	end

	assign rsp_o.data = rdata_q;
	assign rsp_o.ack  = ack_q;

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			led_o      <= '0;
			irq_en_q   <= '0;
			irq_pend_q <= '0;
			irq_o      <= 1'b0;
		end else if (sys_rst_i) begin
			led_o      <= '0;
			irq_en_q   <= '0;
			irq_pend_q <= '0;
			irq_o      <= 1'b0;
		end else begin
			if (wr_en && reg_sel == REG_LED) begin
				led_o <= req_i.data[LED_BITS-1:0];
			end
			if (wr_en && reg_sel == REG_IRQ_EN) begin
				irq_en_q <= req_i.data[BTN_BITS-1:0];
			end
			// a press in the clearing cycle stays pending
			irq_pend_q <= (irq_pend_q & ~pend_clr) | btn_press_i;
			irq_o      <= |(irq_pend_q & irq_en_q);
		end
	end

	// a read of the LED register returns what the LEDs show
	led_readback: assert property (
		@(posedge clk_cpu) disable iff (!rst_n_i)
		rsp_o.ack && $past(reg_sel == REG_LED && !req_i.we)
			|-> rsp_o.data == DATA_BITS'(led_o)
	);

endmodule

// ==== source/dev_decoder.sv ====
`timescale 1ns/10ps

module dev_decoder import sof_bus_pkg::*; (
	input  logic        clk_cpu,
	input  logic        rst_n_i,
	input  logic        sys_rst_i,
	input  dev_req_t    bus_req_i,
	output dev_rsp_t    bus_rsp_o,
	output periph_req_t board_req_o,
	input  dev_rsp_t    board_rsp_i
);

	dev_slot_e slot;
	logic      req_active;
	logic      board_hit;
	logic      empty_hit;
	logic      empty_ack_q;

	assign req_active = bus_req_i.cyc & bus_req_i.stb;

	// top address bits pick the slot
	assign slot = dev_slot_e'(bus_req_i.addr[WORD_ADDR_BITS-1 -: SLOT_BITS]);

	always_comb begin
		board_hit = 1'b0;
		case (slot)
			SLOT_BOARD: board_hit = req_active;
			default:    board_hit = 1'b0;
		endcase
	end

	assign empty_hit = req_active & ~board_hit;

	always_comb begin
		board_req_o.cs     = board_hit;
		board_req_o.offset = bus_req_i.addr[OFFSET_BITS-1:0];
		board_req_o.sel    = bus_req_i.sel;
		board_req_o.we     = bus_req_i.we;
		board_req_o.data   = bus_req_i.data;
	end

	// unpopulated slots still get one ack so the master never stalls
	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			empty_ack_q <= 1'b0;
		end else if (sys_rst_i) begin
			empty_ack_q <= 1'b0;
		end else begin
			empty_ack_q <= empty_hit & ~empty_ack_q;
		end
	end

	always_comb begin
		if (empty_ack_q) begin
			bus_rsp_o.data = '0;
			bus_rsp_o.ack  = 1'b1;
		end else begin
			bus_rsp_o = board_rsp_i;
		end
	end

	// no ack, from either source, without a request one cycle before
	ack_follows_req: assert property (
		@(posedge clk_cpu) disable iff (!rst_n_i)
		bus_rsp_o.ack |-> $past(req_active)
	);

endmodule

// ==== source/rst_seq.sv ====
`timescale 1ns/10ps

module rst_seq import sof_board_pkg::*; (
	input  logic clk_cpu,
	input  logic rst_n_i,
	input  logic pll_locked_i,
	input  logic rst_btn_i,
	output logic sys_rst_o
);

	logic                   rst_req;
	logic [RST_STRETCH-1:0] stretch_q;

	assign rst_req = rst_btn_i | ~pll_locked_i;

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stretch_q <= '1;
		end else begin
			stretch_q <= {stretch_q[RST_STRETCH-2:0], rst_req};
		end
	end

	// held while any request bit is still in the shift register
	assign sys_rst_o = |stretch_q;

	// a reset request keeps the system in reset for the whole stretch
	stretch_holds: assert property (
		@(posedge clk_cpu) disable iff (!rst_n_i)
		rst_req |=> sys_rst_o [*RST_STRETCH]
	);

endmodule

// ==== source/sof_board_pkg.sv ====
package sof_board_pkg;

	localparam int SWITCH_BITS = 8;
	localparam int LED_BITS    = 8;

	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
	} btn_t;

	localparam int BTN_BITS   = $bits(btn_t);
	localparam int INPUT_BITS = SWITCH_BITS + BTN_BITS;

	// word offsets in the board slot
	typedef enum logic [5:0] {
		REG_SWITCH   = 6'd0,
		REG_LED      = 6'd1,
		REG_BTN      = 6'd2,
		REG_IRQ_PEND = 6'd3,
		REG_IRQ_EN   = 6'd4
	} board_reg_e;

	// input must hold this many clk_cpu cycles before it is taken
	localparam int DEBOUNCE_CYCLES   = 8;
	localparam int DEBOUNCE_CNT_BITS = $clog2(DEBOUNCE_CYCLES);

	localparam int RST_STRETCH = 16;

endpackage

// ==== source/sof_bus_pkg.sv ====
package sof_bus_pkg;

	// device space and slot geometry, in bytes
	localparam int DEV_ADDR_BITS  = 16;
	localparam int SLOT_ADDR_BITS = 8;
	localparam int DATA_BITS      = 32;
	localparam int SEL_BITS       = DATA_BITS / 8;

	localparam int WORD_ADDR_BITS = DEV_ADDR_BITS - 2;
	localparam int OFFSET_BITS    = SLOT_ADDR_BITS - 2;
	localparam int SLOT_BITS      = DEV_ADDR_BITS - SLOT_ADDR_BITS;

	// slot number, top address bits
	typedef enum logic [SLOT_BITS-1:0] {
		SLOT_VGA   = 8'd1,
		SLOT_BOARD = 8'd2,
		SLOT_KBD   = 8'd3,
		SLOT_SPI   = 8'd5,
		SLOT_UART  = 8'd6
	} dev_slot_e;

	typedef struct packed {
		logic                      cyc;
		logic                      stb;
		logic [WORD_ADDR_BITS-1:0] addr;
		logic [SEL_BITS-1:0]       sel;
		logic                      we;
		logic [DATA_BITS-1:0]      data;
	} dev_req_t;

	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic                 ack;
	} dev_rsp_t;

	// one peripheral's view, word offset inside its slot
	typedef struct packed {
		logic                   cs;
		logic [OFFSET_BITS-1:0] offset;
		logic [SEL_BITS-1:0]    sel;
		logic                   we;
		logic [DATA_BITS-1:0]   data;
	} periph_req_t;

endpackage

// ==== source/sof_dev_top.sv ====
`timescale 1ns/10ps

module sof_dev_top import sof_bus_pkg::*, sof_board_pkg::*; (
	input  logic                   clk_cpu,
	input  logic                   rst_n_i,
	input  logic                   pll_locked_i,
	input  logic                   rst_btn_i,
	input  dev_req_t               bus_req_i,
	output dev_rsp_t               bus_rsp_o,
	input  logic [SWITCH_BITS-1:0] switch_i,
	input  btn_t                   btn_i,
	output logic [LED_BITS-1:0]    led_o,
	output logic                   irq_o,
	output logic                   sys_rst_o
);

	logic                   sys_rst;
	periph_req_t            board_req;
	dev_rsp_t               board_rsp;
	logic [SWITCH_BITS-1:0] sw_stable;
	btn_t                   btn_stable;
	btn_t                   btn_press;

	assign sys_rst_o = sys_rst;

	rst_seq u_rst_seq (
		.clk_cpu      (clk_cpu),
		.rst_n_i      (rst_n_i),
		.pll_locked_i (pll_locked_i),
		.rst_btn_i    (rst_btn_i),
		.sys_rst_o    (sys_rst)
	);

	dev_decoder u_dev_decoder (
		.clk_cpu     (clk_cpu),
		.rst_n_i     (rst_n_i),
		.sys_rst_i   (sys_rst),
		.bus_req_i   (bus_req_i),
		.bus_rsp_o   (bus_rsp_o),
		.board_req_o (board_req),
		.board_rsp_i (board_rsp)
	);

	// debouncers run free of the system reset
	board_input u_board_input (
		.clk_cpu      (clk_cpu),
		.rst_n_i      (rst_n_i),
		.switch_i     (switch_i),
		.btn_i        (btn_i),
		.sw_stable_o  (sw_stable),
		.btn_stable_o (btn_stable),
		.btn_press_o  (btn_press)
	);

	board_regs u_board_regs (
		.clk_cpu      (clk_cpu),
		.rst_n_i      (rst_n_i),
		.sys_rst_i    (sys_rst),
		.req_i        (board_req),
		.rsp_o        (board_rsp),
		.sw_stable_i  (sw_stable),
		.btn_stable_i (btn_stable),
		.btn_press_i  (btn_press),
		.led_o        (led_o),
		.irq_o        (irq_o)
	);

endmodule
